// ==== common/bram_settings.svh ====
`ifndef BRAM_SETTINGS_SVH
`define BRAM_SETTINGS_SVH

// AXI4-Lite bus widths
`define BRAM_AXI_ADDR_WIDTH 16 // Byte address, bits 15:12 must be zero
`define BRAM_AXI_DATA_WIDTH 32

// Bank organization
`define BRAM_NUM_BANKS 4 // Selected by address bits 11:10
`define BRAM_BANK_ADDR_WIDTH 8 // 256 words per bank
`define BRAM_BANK_SEL_WIDTH 2 // Must cover BRAM_NUM_BANKS

`endif

// ==== common/bram_pkg.sv ====
`default_nettype none

`include "bram_settings.svh"

package bram_pkg;

  // Address field boundaries
  localparam int WORD_LSB = $clog2(`BRAM_AXI_DATA_WIDTH / 8); // Byte offset below this
  localparam int BANK_LSB = WORD_LSB + `BRAM_BANK_ADDR_WIDTH;
  localparam int HIGH_LSB = BANK_LSB + `BRAM_BANK_SEL_WIDTH; // Upper bits, must be zero

  // AXI response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Bank write request, all zero when idle
  typedef struct packed {
    logic                                en;   // Address was in range
    logic [`BRAM_BANK_ADDR_WIDTH-1:0]    addr; // Word index
    logic [`BRAM_AXI_DATA_WIDTH-1:0]     data;
    logic [`BRAM_AXI_DATA_WIDTH/8-1:0]   be;   // Byte enables from wstrb
  } bram_wr_t;

  // Bank read request, broadcast to every bank
  typedef struct packed {
    logic                                en;
    logic [`BRAM_BANK_ADDR_WIDTH-1:0]    addr;
  } bram_rd_t;

endpackage

`default_nettype wire

// ==== axi_bram_writer/axi_bram_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module axi_bram_writer
(
  input  wire                                aclk,
  input  wire                                aresetn,

  input  wire  [`BRAM_AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  wire                                s_axi_awvalid,
  output logic                               s_axi_awready,
  input  wire  [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  wire  [`BRAM_AXI_DATA_WIDTH/8-1:0]  s_axi_wstrb,
  input  wire                                s_axi_wvalid,
  output logic                               s_axi_wready,
  output logic [1:0]                         s_axi_bresp,
  output logic                               s_axi_bvalid,
  input  wire                                s_axi_bready,

  output bram_pkg::bram_wr_t                 wr_req,     // Shared by all banks
  output logic [`BRAM_NUM_BANKS-1:0]         wr_bank_sel // One-hot bank strobe
);

  logic                               awready_reg, awready_next;
  logic                               bvalid_reg, bvalid_next;
  logic [1:0]                         bresp_reg;
  logic                               aw_hs;
  logic                               addr_err;
  logic [`BRAM_BANK_SEL_WIDTH-1:0]    aw_bank;

  assign aw_hs = awready_reg & s_axi_awvalid & s_axi_wvalid; // Both channels transfer here
  assign addr_err = |s_axi_awaddr[`BRAM_AXI_ADDR_WIDTH-1:bram_pkg::HIGH_LSB];
  assign aw_bank = s_axi_awaddr[bram_pkg::HIGH_LSB-1:bram_pkg::BANK_LSB];

  // Ready is a single-cycle pulse, held off while a response is pending
  always_comb
  begin
    awready_next = 1'b0;
    bvalid_next = bvalid_reg;

    if (s_axi_awvalid & s_axi_wvalid & ~awready_reg & ~bvalid_reg)
      awready_next = 1'b1;

    if (aw_hs)
      bvalid_next = 1'b1;

    if (s_axi_bready & bvalid_reg)
      bvalid_next = 1'b0; // Response accepted
  end

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      awready_reg <= 1'b0;
      bvalid_reg <= 1'b0;
      wr_bank_sel <= '0;
    end
    else
    begin
      awready_reg <= awready_next;
      bvalid_reg <= bvalid_next;
      wr_bank_sel <= '0;
      if (aw_hs && !addr_err)
        wr_bank_sel[aw_bank] <= 1'b1; // Valid for one cycle only
    end
  end

  // Request fields and response code
  always_ff @(posedge aclk)
  begin
    wr_req <= '0;
    if (aw_hs)
    begin
      wr_req.en <= ~addr_err;
      wr_req.addr <= s_axi_awaddr[bram_pkg::BANK_LSB-1:bram_pkg::WORD_LSB];
      wr_req.data <= s_axi_wdata;
      wr_req.be <= s_axi_wstrb;
      bresp_reg <= addr_err ? bram_pkg::RESP_SLVERR : bram_pkg::RESP_OKAY;
    end
  end

  assign s_axi_awready = awready_reg;
  assign s_axi_wready = awready_reg; // Address and data accepted together
  assign s_axi_bvalid = bvalid_reg;
  assign s_axi_bresp = bresp_reg;

endmodule

`default_nettype wire

// ==== axi_bram_reader/axi_bram_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module axi_bram_reader
(
  input  wire                                                     aclk,
  input  wire                                                     aresetn,

  input  wire  [`BRAM_AXI_ADDR_WIDTH-1:0]                         s_axi_araddr,
  input  wire                                                     s_axi_arvalid,
  output logic                                                    s_axi_arready,
  output logic [`BRAM_AXI_DATA_WIDTH-1:0]                         s_axi_rdata,
  output logic [1:0]                                              s_axi_rresp,
  output logic                                                    s_axi_rvalid,
  input  wire                                                     s_axi_rready,

  input  wire  [`BRAM_NUM_BANKS-1:0][`BRAM_AXI_DATA_WIDTH-1:0]    bank_rd_data,
  output bram_pkg::bram_rd_t                                      rd_req
);

  logic                               arready_reg;
  logic                               rd_pend_reg; // Bank read in flight
  logic                               rvalid_reg;
  logic [`BRAM_BANK_SEL_WIDTH-1:0]    rd_bank_reg;
  logic                               rd_err_reg;
  logic [`BRAM_AXI_DATA_WIDTH-1:0]    rdata_reg;
  logic [1:0]                         rresp_reg;
  logic                               ar_start;
  logic                               ar_hs;

  // Only one read in progress at a time
  assign ar_start = s_axi_arvalid & ~arready_reg & ~rd_pend_reg & ~rvalid_reg;
  assign ar_hs = arready_reg & s_axi_arvalid;

  // Every bank reads the same word index, the latched bank number picks one later
  assign rd_req = '{en: arready_reg,
                    addr: s_axi_araddr[bram_pkg::BANK_LSB-1:bram_pkg::WORD_LSB]};

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      arready_reg <= 1'b0;
      rd_pend_reg <= 1'b0;
      rvalid_reg <= 1'b0;
    end
    else
    begin
      arready_reg <= ar_start; // Single-cycle pulse
      rd_pend_reg <= ar_hs;
      if (rd_pend_reg)
        rvalid_reg <= 1'b1;
      else if (s_axi_rready & rvalid_reg)
        rvalid_reg <= 1'b0;
    end
  end

  // Bank number and range check ride along with the bank latency
  always_ff @(posedge aclk)
  begin
    if (ar_hs)
    begin
      rd_bank_reg <= s_axi_araddr[bram_pkg::HIGH_LSB-1:bram_pkg::BANK_LSB];
      rd_err_reg <= |s_axi_araddr[`BRAM_AXI_ADDR_WIDTH-1:bram_pkg::HIGH_LSB];
    end

    if (rd_pend_reg)
    begin
      rdata_reg <= rd_err_reg ? '0 : bank_rd_data[rd_bank_reg];
      rresp_reg <= rd_err_reg ? bram_pkg::RESP_SLVERR : bram_pkg::RESP_OKAY;
    end
  end

  assign s_axi_arready = arready_reg;
  assign s_axi_rvalid = rvalid_reg;
  assign s_axi_rdata = rdata_reg; // Held until rready
  assign s_axi_rresp = rresp_reg;

endmodule

`default_nettype wire

// ==== verilog/bram_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module bram_bank
(
  input  wire                                aclk,
  input  wire                                wr_sel,  // This bank is targeted
  input  wire  bram_pkg::bram_wr_t           wr_req,
  input  wire  bram_pkg::bram_rd_t           rd_req,
  output logic [`BRAM_AXI_DATA_WIDTH-1:0]    rd_data
);

  localparam int DEPTH = 1 << `BRAM_BANK_ADDR_WIDTH;
  localparam int NUM_BYTES = `BRAM_AXI_DATA_WIDTH / 8;

  logic [`BRAM_AXI_DATA_WIDTH-1:0] mem [0:DEPTH-1];

  logic wr_en;

  assign wr_en = wr_sel & wr_req.en;

  // Byte-lane writes
  always_ff @(posedge aclk)
  begin
    for (int b = 0; b < NUM_BYTES; b++)
    begin
      if (wr_en && wr_req.be[b])
        mem[wr_req.addr][8*b +: 8] <= wr_req.data[8*b +: 8];
    end
  end

  // Registered read port, one cycle of latency
  always_ff @(posedge aclk)
  begin
    if (rd_req.en)
      rd_data <= mem[rd_req.addr];
  end

endmodule

`default_nettype wire

// ==== verilog/bram_subsystem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module bram_subsystem_top
(
  input  wire                                aclk,
  input  wire                                aresetn,

  // Write channels
  input  wire  [`BRAM_AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  wire                                s_axi_awvalid,
  output logic                               s_axi_awready,
  input  wire  [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  wire  [`BRAM_AXI_DATA_WIDTH/8-1:0]  s_axi_wstrb,
  input  wire                                s_axi_wvalid,
  output logic                               s_axi_wready,
  output logic [1:0]                         s_axi_bresp,
  output logic                               s_axi_bvalid,
  input  wire                                s_axi_bready,

  // Read channels
  input  wire  [`BRAM_AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
  input  wire                                s_axi_arvalid,
  output logic                               s_axi_arready,
  output logic [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                         s_axi_rresp,
  output logic                               s_axi_rvalid,
  input  wire                                s_axi_rready
);

  bram_pkg::bram_wr_t                                    wr_req;
  logic [`BRAM_NUM_BANKS-1:0]                            wr_bank_sel;
  bram_pkg::bram_rd_t                                    rd_req;
  logic [`BRAM_NUM_BANKS-1:0][`BRAM_AXI_DATA_WIDTH-1:0]  bank_rd_data;

  axi_bram_writer i_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_req        (wr_req),
    .wr_bank_sel   (wr_bank_sel)
  );

  // Write request and read request go to every bank
  for (genvar i = 0; i < `BRAM_NUM_BANKS; i++)
  begin : g_bank
    bram_bank i_bank (
      .aclk    (aclk),
      .wr_sel  (wr_bank_sel[i]),
      .wr_req  (wr_req),
      .rd_req  (rd_req),
      .rd_data (bank_rd_data[i])
    );
  end

  axi_bram_reader i_reader (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .bank_rd_data  (bank_rd_data),
    .rd_req        (rd_req)
  );

endmodule

`default_nettype wire

// ==== testbench/bram_subsystem_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module bram_subsystem_sva
(
  input wire                               aclk,
  input wire                               aresetn,
  input wire                               s_axi_awvalid,
  input wire                               s_axi_awready,
  input wire                               s_axi_wvalid,
  input wire                               s_axi_wready,
  input wire [1:0]                         s_axi_bresp,
  input wire                               s_axi_bvalid,
  input wire                               s_axi_bready,
  input wire                               s_axi_arready,
  input wire [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  input wire [1:0]                         s_axi_rresp,
  input wire                               s_axi_rvalid,
  input wire                               s_axi_rready
);

  int unsigned fail_count = 0; // Assertion failures so far

  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else
    begin
      $error("B response changed before bready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
    else
    begin
      $error("R response changed before rready");
      fail_count++;
    end

  a_ready_pair: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_awready == s_axi_wready)
    else
    begin
      $error("awready and wready differ");
      fail_count++;
    end

  a_aw_rise: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(s_axi_awready) |-> s_axi_awvalid && s_axi_wvalid)
    else
    begin
      $error("awready rose without both write valids");
      fail_count++;
    end

  a_aw_pending: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid |-> !s_axi_awready)
    else
    begin
      $error("Write accepted while a B response is pending");
      fail_count++;
    end

  a_ar_pending: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid |-> !s_axi_arready)
    else
    begin
      $error("Read accepted while an R response is pending");
      fail_count++;
    end

  // Outputs settle one edge into reset
  a_reset_idle: assert property (@(posedge aclk)
    !aresetn |=> !s_axi_awready && !s_axi_wready && !s_axi_bvalid &&
                 !s_axi_arready && !s_axi_rvalid)
    else
    begin
      $error("Ready or valid output high during reset");
      fail_count++;
    end

endmodule

bind bram_subsystem_top bram_subsystem_sva i_sva (.*);

`default_nettype wire

// ==== testbench/tb_bram_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bram_settings.svh"

module tb_bram_subsystem;

  localparam int NUM_TXN = 82;       // AXI transactions issued by all tests
  localparam int TXN_BOUND_NS = 400; // Generous upper time per transaction

  logic                               aclk;
  logic                               aresetn;
  logic [`BRAM_AXI_ADDR_WIDTH-1:0]    s_axi_awaddr;
  logic                               s_axi_awvalid;
  logic                               s_axi_awready;
  logic [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_wdata;
  logic [`BRAM_AXI_DATA_WIDTH/8-1:0]  s_axi_wstrb;
  logic                               s_axi_wvalid;
  logic                               s_axi_wready;
  logic [1:0]                         s_axi_bresp;
  logic                               s_axi_bvalid;
  logic                               s_axi_bready;
  logic [`BRAM_AXI_ADDR_WIDTH-1:0]    s_axi_araddr;
  logic                               s_axi_arvalid;
  logic                               s_axi_arready;
  logic [`BRAM_AXI_DATA_WIDTH-1:0]    s_axi_rdata;
  logic [1:0]                         s_axi_rresp;
  logic                               s_axi_rvalid;
  logic                               s_axi_rready;

  logic [31:0] ref_mem [0:1023]; // Indexed by bank number and word index
  logic [31:0] rand_state;

  bram_subsystem_top i_dut (.*);

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic int rand_delay();
    logic [31:0] r;
    r = next_rand();
    return 1 + (r[31:16] % 6);
  endfunction

  function automatic logic [15:0] rand_addr();
    logic [31:0] r;
    r = next_rand();
    return {4'h0, r[27:16]}; // In range, random byte offset
  endfunction

  function automatic logic [1:0] expected_resp(input logic [15:0] addr);
    return (addr[15:12] != 4'h0) ? bram_pkg::RESP_SLVERR : bram_pkg::RESP_OKAY;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("MISMATCH at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped at the first error");
    end
  endtask

  task automatic start_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    s_axi_awaddr <= addr;
    s_axi_wdata <= data;
    s_axi_wstrb <= strb;
    s_axi_awvalid <= 1'b1;
    s_axi_wvalid <= 1'b1;
  endtask

  // Address channel leads the data channel by two cycles
  task automatic start_write_addr_first(input logic [15:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
    s_axi_awaddr <= addr;
    s_axi_awvalid <= 1'b1;
    repeat (2) @(posedge aclk);
    s_axi_wdata <= data;
    s_axi_wstrb <= strb;
    s_axi_wvalid <= 1'b1;
  endtask

  // Waits for the address and data handshake, then merges the enabled bytes
  task automatic finish_aw(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    do
      @(posedge aclk);
    while (!s_axi_awready);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid <= 1'b0;
    if (addr[15:12] == 4'h0)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (strb[b])
          ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic finish_b(input logic [15:0] addr, input int hold);
    do
      @(posedge aclk);
    while (!s_axi_bvalid);
    check_value("s_axi_bresp", expected_resp(addr), s_axi_bresp);
    repeat (hold)
    begin
      @(posedge aclk);
      check_value("s_axi_awready", 32'h0, s_axi_awready); // Held off by pending B
    end
    s_axi_bready <= 1'b1;
    @(posedge aclk);
    s_axi_bready <= 1'b0;
  endtask

  task automatic write_txn(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold);
    start_write(addr, data, strb);
    finish_aw(addr, data, strb);
    finish_b(addr, hold);
  endtask

  task automatic start_read(input logic [15:0] addr);
    s_axi_araddr <= addr;
    s_axi_arvalid <= 1'b1;
  endtask

  task automatic finish_ar();
    do
      @(posedge aclk);
    while (!s_axi_arready);
    s_axi_arvalid <= 1'b0;
  endtask

  task automatic finish_r(input logic [15:0] addr, input int hold);
    logic [31:0] exp_data;
    exp_data = (addr[15:12] == 4'h0) ? ref_mem[addr[11:2]] : 32'h0;
    do
      @(posedge aclk);
    while (!s_axi_rvalid);
    check_value("s_axi_rresp", expected_resp(addr), s_axi_rresp);
    check_value("s_axi_rdata", exp_data, s_axi_rdata);
    repeat (hold)
    begin
      @(posedge aclk);
      check_value("s_axi_arready", 32'h0, s_axi_arready); // Held off by pending R
    end
    s_axi_rready <= 1'b1;
    @(posedge aclk);
    s_axi_rready <= 1'b0;
  endtask

  task automatic read_txn(input logic [15:0] addr, input int hold);
    start_read(addr);
    finish_ar();
    finish_r(addr, hold);
  endtask

  // Bound assertions count their failures
  always @(i_dut.i_sva.fail_count)
  begin
    if (i_dut.i_sva.fail_count != 0)
    begin
      $display("A bound protocol assertion failed");
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped at the first error");
    end
  end

  initial
  begin
    logic [15:0] addr;
    logic [15:0] addr2;
    logic [15:0] addr_list [0:7];
    logic [31:0] data;
    logic [31:0] data2;
    logic [7:0]  word;
    rand_state = 32'he6a7;
    aresetn = 1'b0;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);

    // Full-word writes with late write data, then read back
    for (int i = 0; i < 8; i++)
    begin
      addr_list[i] = rand_addr();
      data = next_rand();
      start_write_addr_first(addr_list[i], data, 4'hf);
      finish_aw(addr_list[i], data, 4'hf);
      finish_b(addr_list[i], 0);
    end
    for (int i = 0; i < 8; i++)
      read_txn(addr_list[i], 0);

    // Partial strobes merge into a known word
    for (int i = 0; i < 6; i++)
    begin
      addr = rand_addr();
      write_txn(addr, next_rand(), 4'hf, 0);
      data = next_rand();
      write_txn(addr, next_rand(), data[19:16], 0);
      data = next_rand();
      write_txn(addr, next_rand(), data[23:20], 0);
      read_txn(addr, 0);
    end

    // Same word index in every bank
    data = next_rand();
    word = data[23:16];
    for (int b = 0; b < 4; b++)
    begin
      data = next_rand();
      data[31:24] = b[7:0]; // Distinct per bank
      write_txn({4'h0, b[1:0], word, 2'b00}, data, 4'hf, 0);
    end
    for (int b = 0; b < 4; b++)
      read_txn({4'h0, b[1:0], word, 2'b00}, 0);

    // Upper address bits give SLVERR and leave the aliased word alone
    addr = rand_addr();
    write_txn(addr, next_rand(), 4'hf, 0);
    for (int k = 0; k < 4; k++)
    begin
      write_txn(addr | (16'h1000 << k), next_rand(), 4'hf, 0);
      read_txn(addr | (16'h1000 << k), 0);
    end
    read_txn(addr, 0);

    // Back-pressure with the next transaction already waiting
    for (int i = 0; i < 6; i++)
    begin
      addr = rand_addr();
      addr2 = rand_addr();
      data = next_rand();
      data2 = next_rand();
      start_write(addr, data, 4'hf);
      finish_aw(addr, data, 4'hf);
      start_write(addr2, data2, 4'hf);
      finish_b(addr, rand_delay());
      finish_aw(addr2, data2, 4'hf);
      finish_b(addr2, rand_delay());
      start_read(addr);
      finish_ar();
      start_read(addr2);
      finish_r(addr, rand_delay());
      finish_ar();
      finish_r(addr2, rand_delay());
    end

    repeat (4) @(posedge aclk);
    $display("NO ERRORS");
    $finish;
  end

  initial
  begin
    #(16 * 8 + NUM_TXN * TXN_BOUND_NS);
    $display("Timeout: the AXI transactions did not finish within the time bound");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/bram_pkg.sv
axi_bram_writer/axi_bram_writer.sv
axi_bram_reader/axi_bram_reader.sv
verilog/bram_bank.sv
verilog/bram_subsystem_top.sv
testbench/bram_subsystem_sva.sv
testbench/tb_bram_subsystem.sv
